//--- hdl/adpll_pkg.sv
package adpll_pkg;

    localparam int ACCUM_WIDTH   = 12;
    localparam logic [ACCUM_WIDTH-1:0] BIAS = 12'd154; // free-run increment

    localparam int ERR_WIDTH     = 8;  // error saturates at +-127
    localparam int KP_WIDTH      = 5;
    localparam int KP_FRAC_WIDTH = 4;
    localparam int KI_WIDTH      = 7;
    localparam int KI_FRAC_WIDTH = 6;

    localparam int PROP_WIDTH    = ERR_WIDTH + KP_WIDTH + 1; // err * kp product
    localparam int ISTEP_WIDTH   = ERR_WIDTH + KI_WIDTH + 1; // err * ki product
    localparam int INTEG_WIDTH   = ACCUM_WIDTH + KI_FRAC_WIDTH + 1;
    localparam int SUM_WIDTH     = ACCUM_WIDTH + 4; // headroom for the clamp

    localparam int LOCK_THRESH    = 4;  // |err| window in fabric cycles
    localparam int LOCK_COUNT     = 16;
    localparam int LOCK_CNT_WIDTH = $clog2(LOCK_COUNT + 1);

    localparam int FB_DIV_LOG2   = 3; // feedback divide by 8

    localparam int WB_ADDR_WIDTH = 3;
    localparam int WB_DATA_WIDTH = 16;

    localparam logic [KP_WIDTH-1:0]    RST_KP      = 5'd1;
    localparam logic [KI_WIDTH-1:0]    RST_KI      = 7'd1;
    localparam logic [ACCUM_WIDTH-1:0] RST_REF_INC = 12'd19;

    typedef enum logic [WB_ADDR_WIDTH-1:0] {
        REG_CTRL    = 3'd0,
        REG_KP      = 3'd1,
        REG_KI      = 3'd2,
        REG_REF_INC = 3'd3,
        REG_STATUS  = 3'd4,
        REG_ERROR   = 3'd5
    } reg_addr_e;

    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        logic [WB_ADDR_WIDTH-1:0] adr;
        logic [WB_DATA_WIDTH-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                     ack;
        logic [WB_DATA_WIDTH-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic                   enable;
        logic                   ref_ext;  // 1 selects the external reference pin
        logic [KP_WIDTH-1:0]    kp;
        logic [KI_WIDTH-1:0]    ki;
        logic [ACCUM_WIDTH-1:0] ref_inc;
    } pll_cfg_t;

    typedef struct packed {
        logic                        locked;
        logic signed [ERR_WIDTH-1:0] error;
    } pll_status_t;

endpackage

//--- hdl/phase_accum.sv
`timescale 1ns/1ps

module phase_accum #(
    parameter int WIDTH = adpll_pkg::ACCUM_WIDTH
) (
    input  logic             fpga_clk_i,
    input  logic             reset_i,
    input  logic [WIDTH-1:0] k_val_i,
    output logic             clk_o
);

    logic [WIDTH-1:0] accum;

    // wraps freely, so f_out = k_val / 2^WIDTH * f_clk
    always_ff @(posedge fpga_clk_i) begin
        if (reset_i) begin
            accum <= '0;
        end else begin
            accum <= accum + k_val_i;
        end
    end

    assign clk_o = accum[WIDTH-1]; // msb is the square wave

endmodule

//--- hdl/phase_detector.sv
`timescale 1ns/1ps

module phase_detector (
    input  logic                                   fpga_clk_i,
    input  logic                                   reset_i,
    input  logic                                   ref_clk_i,
    input  logic                                   fb_clk_i,
    output logic signed [adpll_pkg::ERR_WIDTH-1:0] err_o,
    output logic                                   err_valid_o
);

    typedef enum logic [1:0] {
        IDLE,
        REF_FIRST,
        FB_FIRST
    } pd_state_e;

    pd_state_e state;
    logic [2:0] ref_sync;  // two sync stages plus edge history
    logic [2:0] fb_sync;
    logic       ref_rise;
    logic       fb_rise;
    logic [adpll_pkg::ERR_WIDTH-2:0] cnt; // magnitude, 0..127

    always_ff @(posedge fpga_clk_i) begin
        if (reset_i) begin
            ref_sync <= '0;
            fb_sync  <= '0;
        end else begin
            ref_sync <= {ref_sync[1:0], ref_clk_i};
            fb_sync  <= {fb_sync[1:0], fb_clk_i};
        end
    end

    assign ref_rise = ref_sync[1] & ~ref_sync[2];
    assign fb_rise  = fb_sync[1] & ~fb_sync[2];

    always_ff @(posedge fpga_clk_i) begin
        if (reset_i) begin
            state       <= IDLE;
            cnt         <= '0;
            err_o       <= '0;
            err_valid_o <= 1'b0;
        end else begin
            err_valid_o <= 1'b0;
            if (cnt != '1) begin
                cnt <= cnt + 1'b1; // saturates at 127
            end
            case (state)
                IDLE: begin
                    if (ref_rise && fb_rise) begin
                        err_o       <= '0; // edges coincide
                        err_valid_o <= 1'b1;
                    end else if (ref_rise) begin
                        state <= REF_FIRST;
                        cnt   <= 1;
                    end else if (fb_rise) begin
                        state <= FB_FIRST;
                        cnt   <= 1;
                    end
                end
                REF_FIRST: begin
                    if (fb_rise) begin
                        err_o       <= $signed({1'b0, cnt}); // reference leads so speed up
                        err_valid_o <= 1'b1;
                        state       <= IDLE;
                    end else if (ref_rise) begin
                        cnt <= 1; // restart from the newer unpaired ref edge
                    end
                end
                FB_FIRST: begin
                    if (ref_rise) begin
                        err_o       <= -$signed({1'b0, cnt});
                        err_valid_o <= 1'b1;
                        state       <= IDLE;
                    end else if (fb_rise) begin
                        cnt <= 1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // the loop filter takes one error per strobe
    valid_single_pulse: assert property (@(posedge fpga_clk_i) disable iff (reset_i)
        err_valid_o |=> !err_valid_o);

endmodule

//--- hdl/loop_filter.sv
`timescale 1ns/1ps

module loop_filter (
    input  logic                                     fpga_clk_i,
    input  logic                                     reset_i,
    input  adpll_pkg::pll_cfg_t                      cfg_i,
    input  logic signed [adpll_pkg::ERR_WIDTH-1:0]   err_i,
    input  logic                                     err_valid_i,
    output logic [adpll_pkg::ACCUM_WIDTH-1:0]        k_val_o,
    output logic                                     locked_o
);

    logic signed [adpll_pkg::PROP_WIDTH-1:0]  prop_full;
    logic signed [adpll_pkg::ISTEP_WIDTH-1:0] integ_step;
    logic signed [adpll_pkg::INTEG_WIDTH:0]   integ_sum;
    logic signed [adpll_pkg::INTEG_WIDTH-1:0] integ_q;  // keeps KI_FRAC_WIDTH fraction bits
    logic signed [adpll_pkg::INTEG_WIDTH-1:0] integ_next;
    logic signed [adpll_pkg::SUM_WIDTH-1:0]   prop_ext;
    logic signed [adpll_pkg::SUM_WIDTH-1:0]   integ_ext;
    logic signed [adpll_pkg::SUM_WIDTH-1:0]   out_sum;
    logic [adpll_pkg::ACCUM_WIDTH-1:0]        k_next;
    logic [adpll_pkg::LOCK_CNT_WIDTH-1:0]     lock_cnt;
    logic                                     in_window;

    assign prop_full  = err_i * $signed({1'b0, cfg_i.kp});
    assign integ_step = err_i * $signed({1'b0, cfg_i.ki});
    assign integ_sum  = (adpll_pkg::INTEG_WIDTH+1)'(integ_q)
                      + (adpll_pkg::INTEG_WIDTH+1)'(integ_step);

    always_comb begin
        // saturate instead of wrapping
        if (integ_sum[adpll_pkg::INTEG_WIDTH] != integ_sum[adpll_pkg::INTEG_WIDTH-1]) begin
            if (integ_sum[adpll_pkg::INTEG_WIDTH]) begin
                integ_next = {1'b1, {(adpll_pkg::INTEG_WIDTH-1){1'b0}}};
            end else begin
                integ_next = {1'b0, {(adpll_pkg::INTEG_WIDTH-1){1'b1}}};
            end
        end else begin
            integ_next = integ_sum[adpll_pkg::INTEG_WIDTH-1:0];
        end
    end

    // drop fraction bits, then widen for the sum
    assign prop_ext  = adpll_pkg::SUM_WIDTH'(
        $signed(prop_full[adpll_pkg::PROP_WIDTH-1:adpll_pkg::KP_FRAC_WIDTH]));
    assign integ_ext = adpll_pkg::SUM_WIDTH'(
        $signed(integ_next[adpll_pkg::INTEG_WIDTH-1:adpll_pkg::KI_FRAC_WIDTH]));
    assign out_sum   = $signed(adpll_pkg::SUM_WIDTH'(adpll_pkg::BIAS)) + prop_ext + integ_ext;

    always_comb begin
        if (out_sum < 1) begin
            k_next = 1; // a zero increment would stop the NCO
        end else if (out_sum > 4095) begin
            k_next = '1;
        end else begin
            k_next = out_sum[adpll_pkg::ACCUM_WIDTH-1:0];
        end
    end

    assign in_window = (err_i <= adpll_pkg::LOCK_THRESH) && (err_i >= -adpll_pkg::LOCK_THRESH);

    always_ff @(posedge fpga_clk_i) begin
        if (reset_i || !cfg_i.enable) begin
            k_val_o  <= adpll_pkg::BIAS;
            integ_q  <= '0;
            lock_cnt <= '0;
            locked_o <= 1'b0;
        end else if (err_valid_i) begin
            k_val_o <= k_next;
            integ_q <= integ_next;
            if (in_window) begin
                if (lock_cnt != adpll_pkg::LOCK_CNT_WIDTH'(adpll_pkg::LOCK_COUNT)) begin
                    lock_cnt <= lock_cnt + 1'b1;
                end
                // lock on the LOCK_COUNT-th good comparison
                locked_o <= lock_cnt >= adpll_pkg::LOCK_CNT_WIDTH'(adpll_pkg::LOCK_COUNT - 1);
            end else begin
                lock_cnt <= '0;
                locked_o <= 1'b0;
            end
        end
    end

    // disabled loop falls back to the free-run frequency
    bias_when_disabled: assert property (@(posedge fpga_clk_i) disable iff (reset_i)
        !cfg_i.enable |=> (k_val_o == adpll_pkg::BIAS));

endmodule

//--- hdl/adpll_core.sv
`timescale 1ns/1ps

module adpll_core #(
    parameter int DIV_LOG2 = adpll_pkg::FB_DIV_LOG2
) (
    input  logic                   fpga_clk_i,
    input  logic                   reset_i,
    input  adpll_pkg::pll_cfg_t    cfg_i,
    input  logic                   ref_clk_i,
    output logic                   gen_clk_o,
    output logic                   gen_div8_o,
    output adpll_pkg::pll_status_t status_o
);

    logic signed [adpll_pkg::ERR_WIDTH-1:0] err;
    logic signed [adpll_pkg::ERR_WIDTH-1:0] err_last;
    logic                                   err_valid;
    logic [adpll_pkg::ACCUM_WIDTH-1:0]      k_val;
    logic                                   locked;
    logic                                   gen_prev;
    logic [DIV_LOG2-1:0]                    div_cnt;

    phase_detector u_pd (
        .fpga_clk_i  (fpga_clk_i),
        .reset_i     (reset_i),
        .ref_clk_i   (ref_clk_i),
        .fb_clk_i    (gen_div8_o), // divided feedback
        .err_o       (err),
        .err_valid_o (err_valid)
    );

    loop_filter u_lf (
        .fpga_clk_i  (fpga_clk_i),
        .reset_i     (reset_i),
        .cfg_i       (cfg_i),
        .err_i       (err),
        .err_valid_i (err_valid),
        .k_val_o     (k_val),
        .locked_o    (locked)
    );

    phase_accum #(.WIDTH(adpll_pkg::ACCUM_WIDTH)) u_nco (
        .fpga_clk_i (fpga_clk_i),
        .reset_i    (reset_i),
        .k_val_i    (k_val),
        .clk_o      (gen_clk_o)
    );

    // count gen_clk rising edges in the fabric domain
    always_ff @(posedge fpga_clk_i) begin
        if (reset_i) begin
            gen_prev <= 1'b0;
            div_cnt  <= '0;
            err_last <= '0;
        end else begin
            gen_prev <= gen_clk_o;
            if (gen_clk_o && !gen_prev) begin
                div_cnt <= div_cnt + 1'b1;
            end
            if (err_valid) begin
                err_last <= err; // held for the status register
            end
        end
    end

    assign gen_div8_o      = div_cnt[DIV_LOG2-1];
    assign status_o.locked = locked;
    assign status_o.error  = err_last;

endmodule

//--- hdl/adpll_regs.sv
`timescale 1ns/1ps

module adpll_regs (
    input  logic                   fpga_clk_i,
    input  logic                   reset_i,
    input  adpll_pkg::wb_req_t     wb_req_i,
    output adpll_pkg::wb_rsp_t     wb_rsp_o,
    input  adpll_pkg::pll_status_t status_a_i,
    input  adpll_pkg::pll_status_t status_b_i,
    output adpll_pkg::pll_cfg_t    cfg_o
);

    adpll_pkg::reg_addr_e              addr;
    logic                              req;
    logic                              armed; // cleared by ack and set again once stb drops
    logic [adpll_pkg::WB_DATA_WIDTH-1:0] rd_data;

    assign addr = adpll_pkg::reg_addr_e'(wb_req_i.adr);
    assign req  = wb_req_i.cyc && wb_req_i.stb && armed;

    always_comb begin
        case (addr)
            adpll_pkg::REG_CTRL:    rd_data = {14'd0, cfg_o.ref_ext, cfg_o.enable};
            adpll_pkg::REG_KP:      rd_data = {11'd0, cfg_o.kp};
            adpll_pkg::REG_KI:      rd_data = {9'd0, cfg_o.ki};
            adpll_pkg::REG_REF_INC: rd_data = {4'd0, cfg_o.ref_inc};
            adpll_pkg::REG_STATUS:  rd_data = {14'd0, status_b_i.locked, status_a_i.locked};
            adpll_pkg::REG_ERROR:   rd_data = {{8{status_a_i.error[7]}}, status_a_i.error};
            default:                rd_data = '0; // unmapped reads zero
        endcase
    end

    always_ff @(posedge fpga_clk_i) begin
        if (reset_i) begin
            wb_rsp_o.ack  <= 1'b0;
            armed         <= 1'b1;
            cfg_o.enable  <= 1'b0;
            cfg_o.ref_ext <= 1'b0;
            cfg_o.kp      <= adpll_pkg::RST_KP;
            cfg_o.ki      <= adpll_pkg::RST_KI;
            cfg_o.ref_inc <= adpll_pkg::RST_REF_INC;
        end else begin
            wb_rsp_o.ack <= req;
            if (req) begin
                armed <= 1'b0;
            end else if (!wb_req_i.stb) begin
                armed <= 1'b1;
            end
            if (req && wb_req_i.we) begin
                case (addr)
                    adpll_pkg::REG_CTRL: begin
                        cfg_o.enable  <= wb_req_i.dat[0];
                        cfg_o.ref_ext <= wb_req_i.dat[1];
                    end
                    adpll_pkg::REG_KP:      cfg_o.kp      <= wb_req_i.dat[4:0];
                    adpll_pkg::REG_KI:      cfg_o.ki      <= wb_req_i.dat[6:0];
                    adpll_pkg::REG_REF_INC: cfg_o.ref_inc <= wb_req_i.dat[11:0];
                    default: ; // status, error and holes are read only
                endcase
            end
        end
    end

    // read data lines up with ack
    always_ff @(posedge fpga_clk_i) begin
        wb_rsp_o.dat <= rd_data;
    end

    // ack answers a request seen on the previous edge
    ack_follows_request: assert property (@(posedge fpga_clk_i) disable iff (reset_i)
        wb_rsp_o.ack |-> $past(wb_req_i.cyc && wb_req_i.stb));

endmodule

//--- hdl/adpll_pair_top.sv
`timescale 1ns/1ps

module adpll_pair_top (
    input  logic               fpga_clk_i,
    input  logic               reset_i,
    input  logic               ext_ref_i,
    input  adpll_pkg::wb_req_t wb_req_i,
    output adpll_pkg::wb_rsp_t wb_rsp_o,
    output logic               gen_ref_o,
    output logic               pll_a_clk_o,
    output logic               pll_b_clk_o
);

    adpll_pkg::pll_cfg_t    cfg;
    adpll_pkg::pll_status_t status_a;
    adpll_pkg::pll_status_t status_b;
    logic                   ref_sel;
    logic                   a_div8; // reference for the second loop

    adpll_regs u_regs (
        .fpga_clk_i (fpga_clk_i),
        .reset_i    (reset_i),
        .wb_req_i   (wb_req_i),
        .wb_rsp_o   (wb_rsp_o),
        .status_a_i (status_a),
        .status_b_i (status_b),
        .cfg_o      (cfg)
    );

    phase_accum #(.WIDTH(adpll_pkg::ACCUM_WIDTH)) u_ref_nco (
        .fpga_clk_i (fpga_clk_i),
        .reset_i    (reset_i),
        .k_val_i    (cfg.ref_inc),
        .clk_o      (gen_ref_o)
    );

    assign ref_sel = cfg.ref_ext ? ext_ref_i : gen_ref_o;

    adpll_core u_pll_a (
        .fpga_clk_i (fpga_clk_i),
        .reset_i    (reset_i),
        .cfg_i      (cfg),
        .ref_clk_i  (ref_sel),
        .gen_clk_o  (pll_a_clk_o),
        .gen_div8_o (a_div8),
        .status_o   (status_a)
    );

    adpll_core u_pll_b (
        .fpga_clk_i (fpga_clk_i),
        .reset_i    (reset_i),
        .cfg_i      (cfg),
        .ref_clk_i  (a_div8),
        .gen_clk_o  (pll_b_clk_o),
        .gen_div8_o (),
        .status_o   (status_b)
    );

endmodule

//--- sim/tb_adpll_pair.sv
`timescale 1ns/1ps

module tb_adpll_pair;

    localparam int NUM_TESTS   = 5;
    localparam int FIELDS      = 8;      // words per test line in the data file
    localparam int SETTLE      = 200000; // lock wait per loop in fabric cycles
    localparam int FREE_WINDOW = 40960;
    localparam int POLL_GAP    = 50;
    localparam int LOCK_THRESH = 4;

    logic               fpga_clk;
    logic               reset;
    logic               ext_ref;
    adpll_pkg::wb_req_t wb_req;
    adpll_pkg::wb_rsp_t wb_rsp;
    logic               gen_ref;
    logic               pll_a_clk;
    logic               pll_b_clk;

    logic [31:0] tdata [0:NUM_TESTS*FIELDS-1];
    int          errors;
    int          fails;
    int          wd_limit;
    int          cycle;
    int          ack_count;
    int          ref_edges;
    int          a_edges;
    int          b_edges;
    logic        ref_prev;
    logic        a_prev;
    logic        b_prev;
    int          ext_half;  // 0 keeps ext_ref low
    int          ext_ofs;
    int          ext_cnt;

    adpll_pair_top DUT (
        .fpga_clk_i  (fpga_clk),
        .reset_i     (reset),
        .ext_ref_i   (ext_ref),
        .wb_req_i    (wb_req),
        .wb_rsp_o    (wb_rsp),
        .gen_ref_o   (gen_ref),
        .pll_a_clk_o (pll_a_clk),
        .pll_b_clk_o (pll_b_clk)
    );

    always #5 fpga_clk = ~fpga_clk;

    // free running edge counters that the windows take differences of
    always @(posedge fpga_clk) begin
        cycle    <= cycle + 1;
        ref_prev <= gen_ref;
        a_prev   <= pll_a_clk;
        b_prev   <= pll_b_clk;
        if (gen_ref && !ref_prev) ref_edges <= ref_edges + 1;
        if (pll_a_clk && !a_prev) a_edges <= a_edges + 1;
        if (pll_b_clk && !b_prev) b_edges <= b_edges + 1;
        if (wb_rsp.ack) ack_count <= ack_count + 1;
    end

    // external reference toggles every ext_half cycles
    always @(posedge fpga_clk) begin
        if (ext_half == 0) begin
            ext_cnt <= ext_ofs; // random start phase
            ext_ref <= 1'b0;
        end else if (ext_cnt >= ext_half - 1) begin
            ext_cnt <= 0;
            ext_ref <= ~ext_ref;
        end else begin
            ext_cnt <= ext_cnt + 1;
        end
    end

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("ERR %s: expected %0d, actual %0d", name, expected, actual);
        errors++;
    endtask

    task automatic bus_access(input logic we, input logic [2:0] adr,
                              input logic [15:0] wdat, output logic [15:0] rdat);
        int start_acks;
        int waited;
        start_acks = ack_count;
        waited     = 0;
        @(posedge fpga_clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        do begin
            @(posedge fpga_clk);
            waited++;
        end while (!wb_rsp.ack && waited < 16);
        rdat = wb_rsp.dat;
        wb_req <= '0;
        if (!wb_rsp.ack) begin
            $display("bus access to address %0d was never acknowledged", adr);
            fails++;
        end
        repeat (2) @(posedge fpga_clk); // a second ack would show up here
        if (ack_count - start_acks != 1) begin
            report_mismatch($sformatf("acks for address %0d", adr), 1, ack_count - start_acks);
        end
        repeat ($urandom % 4) @(posedge fpga_clk);
    endtask

    task automatic measure(input int cycles, output int ref_n, output int a_n, output int b_n);
        int r0;
        int a0;
        int b0;
        @(posedge fpga_clk);
        r0 = ref_edges;
        a0 = a_edges;
        b0 = b_edges;
        repeat (cycles) @(posedge fpga_clk);
        ref_n = ref_edges - r0;
        a_n   = a_edges - a0;
        b_n   = b_edges - b0;
    endtask

    task automatic wait_locked(input logic [1:0] mask, input string what);
        logic [15:0] rd;
        int          t0;
        t0 = cycle;
        bus_access(1'b0, adpll_pkg::REG_STATUS, 16'd0, rd);
        while ((rd[1:0] & mask) != mask && cycle - t0 < SETTLE) begin
            repeat (POLL_GAP) @(posedge fpga_clk);
            bus_access(1'b0, adpll_pkg::REG_STATUS, 16'd0, rd);
        end
        if ((rd[1:0] & mask) != mask) begin
            $display("%s did not lock within %0d cycles", what, SETTLE);
            fails++;
        end
    endtask

    task automatic check_free_run(input string name);
        logic [15:0] rd;
        int          r;
        int          a;
        int          b;
        int          expect_n;
        expect_n = int'(adpll_pkg::BIAS) * FREE_WINDOW / 4096;
        measure(FREE_WINDOW, r, a, b);
        if (a < expect_n - 1 || a > expect_n + 1) begin
            report_mismatch({name, " pll_a free run"}, expect_n, a);
        end
        if (b < expect_n - 1 || b > expect_n + 1) begin
            report_mismatch({name, " pll_b free run"}, expect_n, b);
        end
        bus_access(1'b0, adpll_pkg::REG_STATUS, 16'd0, rd);
        if (rd != 16'd0) report_mismatch({name, " status"}, 0, rd);
    endtask

    initial begin
        int          wr_adr [6] = '{0, 1, 2, 3, 4, 6};
        int          wr_val [6] = '{2, 21, 90, 2748, 65535, 4660};
        int          rb_val [6] = '{2, 21, 90, 2748, 0, 0}; // status and holes stay 0
        logic [15:0] rd;
        int          r;
        int          a;
        int          b;
        int          exp_v;
        int          mode;
        int          ref_val;
        int          win;
        int          tol;
        int          err_val;
        string       name;
        fpga_clk = 1'b0;
        reset    = 1'b1;
        ext_ref  = 1'b0;
        wb_req   = '0;
        ext_half = 0;
        ext_ofs  = 0;
        void'($urandom(32'hac6ccdfb));
        $readmemh("sim/adpll_testdata.txt", tdata);
        wd_limit = FREE_WINDOW + 5000;
        for (int t = 0; t < NUM_TESTS; t++) begin
            wd_limit += 2 * int'(tdata[t*FIELDS+4]) + FREE_WINDOW + 2 * SETTLE + 5000;
        end
        repeat (5) @(posedge fpga_clk);
        reset <= 1'b0;

        for (int adr = 0; adr < 8; adr++) begin
            if (adr != 5) begin // error register moves on its own
                bus_access(1'b0, 3'(adr), 16'd0, rd);
                exp_v = (adr == 1 || adr == 2) ? 1 : (adr == 3) ? 19 : 0;
                if (rd != exp_v) begin
                    report_mismatch($sformatf("reset value at %0d", adr), exp_v, rd);
                end
            end
        end
        for (int i = 0; i < 6; i++) begin
            bus_access(1'b1, 3'(wr_adr[i]), 16'(wr_val[i]), rd);
            bus_access(1'b0, 3'(wr_adr[i]), 16'd0, rd);
            if (rd != rb_val[i]) begin
                report_mismatch($sformatf("readback at %0d", wr_adr[i]), rb_val[i], rd);
            end
        end
        bus_access(1'b1, adpll_pkg::REG_CTRL, 16'd0, rd);
        check_free_run("after reset");

        for (int t = 0; t < NUM_TESTS; t++) begin
            mode    = tdata[t*FIELDS];
            ref_val = tdata[t*FIELDS+1];
            win     = tdata[t*FIELDS+4];
            tol     = tdata[t*FIELDS+5];
            name    = $sformatf("test %0d", t);
            bus_access(1'b1, adpll_pkg::REG_CTRL, 16'd0, rd); // restart from free run
            bus_access(1'b1, adpll_pkg::REG_KP, 16'(tdata[t*FIELDS+2]), rd);
            bus_access(1'b1, adpll_pkg::REG_KI, 16'(tdata[t*FIELDS+3]), rd);
            if (mode == 0) begin
                bus_access(1'b1, adpll_pkg::REG_REF_INC, 16'(ref_val), rd);
                measure(win, r, a, b);
                exp_v = tdata[t*FIELDS+6];
                if (r < exp_v - 1 || r > exp_v + 1) begin
                    report_mismatch({name, " reference edges"}, exp_v, r);
                end
            end else begin
                @(posedge fpga_clk);
                ext_ofs <= int'($urandom % ref_val);
                @(posedge fpga_clk);
                ext_half <= ref_val;
            end
            bus_access(1'b1, adpll_pkg::REG_CTRL, (mode != 0) ? 16'd3 : 16'd1, rd);

            wait_locked(2'b01, {name, " PLL A"});
            bus_access(1'b0, adpll_pkg::REG_ERROR, 16'd0, rd);
            err_val = int'($signed(rd));
            if (err_val > LOCK_THRESH || err_val < -LOCK_THRESH) begin
                report_mismatch({name, " locked error magnitude"}, LOCK_THRESH, err_val);
            end
            wait_locked(2'b11, {name, " PLL B"});
            measure(win, r, a, b);
            exp_v = tdata[t*FIELDS+7];
            if (a < exp_v - tol || a > exp_v + tol) begin
                report_mismatch({name, " pll_a edges"}, exp_v, a);
            end
            if (b < exp_v - tol || b > exp_v + tol) begin
                report_mismatch({name, " pll_b edges"}, exp_v, b);
            end

            bus_access(1'b1, adpll_pkg::REG_CTRL, 16'd0, rd);
            @(posedge fpga_clk);
            ext_half <= 0;
            check_free_run(name);
        end

        $display("summary: %0d value errors, %0d other failures", errors, fails);
        if (errors == 0 && fails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        wait (wd_limit != 0);
        repeat (wd_limit) @(posedge fpga_clk);
        $display("timeout, the tests did not finish within %0d cycles", wd_limit);
        $display("summary: %0d value errors, %0d other failures", errors, fails + 1);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- sim/adpll_testdata.txt
// hex columns: mode ref kp ki window tol exp_ref exp_pll
// mode 0: ref is the NCO increment; mode 1: ref is the ext_ref_i half period in cycles
// exp_ref counts reference edges per window, exp_pll counts pll_a edges (8x reference)
0 13 4 2 A000 10 BE 5F0
0 12 8 4 A000 10 B4 5A0
0 14 4 2 A000 10 C8 640
0 15 6 3 A000 10 D2 690
1 80 4 2 A000 10 A0 500

//--- sim.f
hdl/adpll_pkg.sv
hdl/phase_accum.sv
hdl/phase_detector.sv
hdl/loop_filter.sv
hdl/adpll_core.sv
hdl/adpll_regs.sv
hdl/adpll_pair_top.sv
sim/tb_adpll_pair.sv

//--- Makefile
BIN  := obj_dir/Vtb_adpll_pair
SRCS := $(shell cat sim.f)

.PHONY: all run clean

all: run

$(BIN): sim.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_adpll_pair -Mdir obj_dir

run: $(BIN) sim/adpll_testdata.txt
	$(BIN) | tee sim.log
	grep -q "^RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
